/* compile.f */
+incdir+include
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/riscv_core.sv
test/tb_riscv_core.sv

/* hdl/riscv_core.sv */
`timescale 1ns/1ns

module riscv_core #(
    parameter int unsigned   MEM_BYTES    = rv_pkg::DEFAULT_MEM_BYTES,
    parameter rv_pkg::word_t UART_TX_ADDR = rv_pkg::DEFAULT_UART_TX_ADDR
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          i_prog_en,
    input  rv_pkg::word_t i_prog_addr,
    input  logic [7:0]    i_prog_data,
    output logic          o_uart_en,
    output logic [7:0]    o_uart_data
);
    import rv_pkg::*;

    word_t     inst;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     result;
    word_t     load_data;
    word_t     addr;
    word_t     store_data;
    word_t     pc;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    alu_op_t   alu_op;
    br_cond_t  br_cond;
    mem_size_t mem_size;
    logic      use_imm;
    logic      jal;
    logic      jalr;
    logic      auipc;
    logic      load;
    logic      store;
    logic      mem_unsigned;
    logic      reg_write;
    logic      we;                                      // reset-gated write-back
    logic [3:0] byte_en;

    rv_decode u_decode (
        .i_inst(inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(alu_op), .o_use_imm(use_imm), .o_br_cond(br_cond),
        .o_jal(jal), .o_jalr(jalr), .o_auipc(auipc), .o_load(load), .o_store(store),
        .o_mem_size(mem_size), .o_mem_unsigned(mem_unsigned), .o_reg_write(reg_write)
    );

    rv_regfile u_regfile (
        .clk(clk), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd), .i_we(we), .i_load(load),
        .i_alu_result(result), .i_load_data(load_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    rv_execute #(.UART_TX_ADDR(UART_TX_ADDR)) u_execute (
        .clk(clk), .reset(reset), .i_alu_op(alu_op), .i_use_imm(use_imm), .i_imm(imm),
        .i_br_cond(br_cond), .i_jal(jal), .i_jalr(jalr), .i_auipc(auipc),
        .i_load(load), .i_store(store), .i_mem_size(mem_size),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_reg_write(reg_write),
        .o_we(we), .o_result(result), .o_addr(addr), .o_byte_en(byte_en),
        .o_store_data(store_data), .o_pc(pc),
        .o_uart_en(o_uart_en), .o_uart_data(o_uart_data)
    );

    rv_memory #(.MEM_BYTES(MEM_BYTES)) u_memory (
        .clk(clk), .reset(reset), .i_pc(pc), .i_addr(addr), .i_byte_en(byte_en),
        .i_store_data(store_data), .i_size(mem_size), .i_unsigned(mem_unsigned),
        .i_prog_en(i_prog_en), .i_prog_addr(i_prog_addr), .i_prog_data(i_prog_data),
        .o_inst(inst), .o_load_data(load_data)
    );

endmodule

/* hdl/rv_decode.sv */
`timescale 1ns/1ns

module rv_decode (
    input  rv_pkg::word_t     i_inst,
    output rv_pkg::reg_idx_t  o_rs1,
    output rv_pkg::reg_idx_t  o_rs2,
    output rv_pkg::reg_idx_t  o_rd,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::alu_op_t   o_alu_op,
    output logic              o_use_imm,
    output rv_pkg::br_cond_t  o_br_cond,
    output logic              o_jal,
    output logic              o_jalr,
    output logic              o_auipc,
    output logic              o_load,
    output logic              o_store,
    output rv_pkg::mem_size_t o_mem_size,
    output logic              o_mem_unsigned,
    output logic              o_reg_write
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       op_ok;                                  // legal funct7 for r-type
    logic       shift_ok;                               // legal funct7 for shift-immediates
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign o_rd   = i_inst[11:7];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    assign op_ok    = (funct7 == 7'h00) ||
                      ((funct7 == 7'h20) && (funct3 == 3'b000 || funct3 == 3'b101));
    assign shift_ok = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                      (funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;

    always_comb begin
        o_imm          = '0;
        o_alu_op       = ALU_ADD;
        o_use_imm      = 1'b0;
        o_br_cond      = BR_NONE;
        o_jal          = 1'b0;
        o_jalr         = 1'b0;
        o_auipc        = 1'b0;
        o_load         = 1'b0;
        o_store        = 1'b0;
        o_mem_size     = MEM_WORD;
        o_mem_unsigned = 1'b0;
        o_reg_write    = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                o_use_imm   = (opcode == OPC_OP_IMM);
                o_imm       = imm_i;                    // shamt sits in imm[4:0]
                o_reg_write = (opcode == OPC_OP) ? op_ok : shift_ok;
                case (funct3)
                    3'b000:  o_alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001:  o_alu_op = ALU_SLL;
                    3'b010:  o_alu_op = ALU_SLT;
                    3'b011:  o_alu_op = ALU_SLTU;
                    3'b100:  o_alu_op = ALU_XOR;
                    3'b101:  o_alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  o_alu_op = ALU_OR;
                    default: o_alu_op = ALU_AND;
                endcase
            end
            OPC_LOAD: begin
                o_use_imm      = 1'b1;
                o_imm          = imm_i;
                o_mem_unsigned = funct3[2];
                o_mem_size     = (funct3[1:0] == 2'b00) ? MEM_BYTE :
                                 (funct3[1:0] == 2'b01) ? MEM_HALF : MEM_WORD;
                o_load         = (funct3 == 3'b000) || (funct3 == 3'b001) ||
                                 (funct3 == 3'b010) || (funct3 == 3'b100) || (funct3 == 3'b101);
                o_reg_write    = o_load;
            end
            OPC_STORE: begin
                o_use_imm  = 1'b1;
                o_imm      = imm_s;
                o_mem_size = (funct3 == 3'b000) ? MEM_BYTE :
                             (funct3 == 3'b001) ? MEM_HALF : MEM_WORD;
                o_store    = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                o_imm = imm_b;
                case (funct3)
                    3'b000:  o_br_cond = BR_EQ;
                    3'b001:  o_br_cond = BR_NE;
                    3'b100:  o_br_cond = BR_LT;
                    3'b101:  o_br_cond = BR_GE;
                    3'b110:  o_br_cond = BR_LTU;
                    3'b111:  o_br_cond = BR_GEU;
                    default: o_br_cond = BR_NONE;       // 010 and 011 are reserved
                endcase
            end
            OPC_JAL: begin
                o_imm       = imm_j;
                o_jal       = 1'b1;
                o_reg_write = 1'b1;
            end
            OPC_JALR: begin
                o_use_imm   = 1'b1;
                o_imm       = imm_i;
                o_jalr      = (funct3 == 3'b000);
                o_reg_write = o_jalr;
            end
            OPC_LUI: begin
                o_use_imm   = 1'b1;
                o_imm       = imm_u;
                o_alu_op    = ALU_PASS_B;
                o_reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                o_use_imm   = 1'b1;
                o_imm       = imm_u;
                o_auipc     = 1'b1;                     // pc feeds alu operand a
                o_reg_write = 1'b1;
            end
            default: ;                                  // fence, system etc. act as no-ops
        endcase
    end

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/1ns

module rv_execute #(
    parameter rv_pkg::word_t UART_TX_ADDR = rv_pkg::DEFAULT_UART_TX_ADDR
) (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::alu_op_t   i_alu_op,
    input  logic              i_use_imm,
    input  rv_pkg::word_t     i_imm,
    input  rv_pkg::br_cond_t  i_br_cond,
    input  logic              i_jal,
    input  logic              i_jalr,
    input  logic              i_auipc,
    input  logic              i_load,
    input  logic              i_store,
    input  rv_pkg::mem_size_t i_mem_size,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    input  logic              i_reg_write,
    output logic              o_we,
    output rv_pkg::word_t     o_result,
    output rv_pkg::word_t     o_addr,
    output logic [3:0]        o_byte_en,
    output rv_pkg::word_t     o_store_data,
    output rv_pkg::word_t     o_pc,
    output logic              o_uart_en,
    output logic [7:0]        o_uart_data
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_plus_4;
    word_t next_pc;
    word_t op_a;
    word_t op_b;
    word_t alu_out;
    logic  br_taken;

    assign pc_plus_4 = pc + 32'd4;
    assign op_a      = i_auipc ? pc : i_rs1_data;
    assign op_b      = i_use_imm ? i_imm : i_rs2_data;

    always_comb begin
        case (i_alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = word_t'(op_a < op_b);
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;          // add also forms addresses and jalr targets
        endcase
    end

    //////////////////////////////
    // branch and next pc

    always_comb begin
        case (i_br_cond)
            BR_EQ:   br_taken = (i_rs1_data == i_rs2_data);
            BR_NE:   br_taken = (i_rs1_data != i_rs2_data);
            BR_LT:   br_taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            BR_GE:   br_taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            BR_LTU:  br_taken = (i_rs1_data < i_rs2_data);
            BR_GEU:  br_taken = (i_rs1_data >= i_rs2_data);
            default: br_taken = 1'b0;
        endcase
    end

    assign next_pc = i_jalr              ? {alu_out[XLEN-1:1], 1'b0} :
                     (i_jal || br_taken) ? pc + i_imm : pc_plus_4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    assign o_pc     = pc;
    assign o_result = (i_jal || i_jalr) ? pc_plus_4 : alu_out;   // link value on jumps
    assign o_we     = i_reg_write & ~reset;

    //////////////////////////////
    // load/store address and lanes

    always_comb begin
        o_addr       = '0;
        o_byte_en    = 4'b0000;
        o_store_data = i_rs2_data;
        if (i_load || i_store) begin
            case (i_mem_size)
                MEM_BYTE: o_addr = alu_out;
                MEM_HALF: o_addr = {alu_out[XLEN-1:1], 1'b0};
                default:  o_addr = {alu_out[XLEN-1:2], 2'b00};
            endcase
        end
        if (i_store && !reset) begin
            case (i_mem_size)
                MEM_BYTE: begin
                    o_byte_en    = 4'b0001 << alu_out[1:0];
                    o_store_data = {4{i_rs2_data[7:0]}};     // byte on every lane
                end
                MEM_HALF: begin
                    o_byte_en    = 4'b0011 << {alu_out[1], 1'b0};
                    o_store_data = {2{i_rs2_data[15:0]}};
                end
                default: o_byte_en = 4'b1111;
            endcase
        end
    end

    // sb to the tx address strobes the uart for this cycle
    assign o_uart_en   = i_store & ~reset & (i_mem_size == MEM_BYTE) & (alu_out == UART_TX_ADDR);
    assign o_uart_data = i_rs2_data[7:0];

endmodule

/* hdl/rv_memory.sv */
`timescale 1ns/1ns

module rv_memory #(
    parameter int unsigned MEM_BYTES = rv_pkg::DEFAULT_MEM_BYTES
) (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::word_t     i_pc,
    input  rv_pkg::word_t     i_addr,
    input  logic [3:0]        i_byte_en,
    input  rv_pkg::word_t     i_store_data,
    input  rv_pkg::mem_size_t i_size,
    input  logic              i_unsigned,
    input  logic              i_prog_en,
    input  rv_pkg::word_t     i_prog_addr,
    input  logic [7:0]        i_prog_data,
    output rv_pkg::word_t     o_inst,
    output rv_pkg::word_t     o_load_data
);
    import rv_pkg::*;

    localparam int AW = $clog2(MEM_BYTES);              // byte address bits

    logic [7:0]    mem [MEM_BYTES];
    logic [AW-1:0] pc_idx;
    logic [AW-1:0] ld_idx;
    logic [AW-3:0] st_word;
    logic [AW-1:0] prog_idx;
    logic          in_range;                            // store lands inside the array
    logic [7:0]    ld_b0;
    logic [7:0]    ld_b1;
    logic [7:0]    ld_b2;
    logic [7:0]    ld_b3;

    assign pc_idx   = i_pc[AW-1:0];
    assign ld_idx   = i_addr[AW-1:0];
    assign st_word  = i_addr[AW-1:2];
    assign prog_idx = i_prog_addr[AW-1:0];
    assign in_range = (i_addr < word_t'(MEM_BYTES));

    // little-endian fetch
    assign o_inst = {mem[pc_idx + AW'(3)], mem[pc_idx + AW'(2)],
                     mem[pc_idx + AW'(1)], mem[pc_idx]};

    assign ld_b0 = mem[ld_idx];
    assign ld_b1 = mem[ld_idx + AW'(1)];
    assign ld_b2 = mem[ld_idx + AW'(2)];
    assign ld_b3 = mem[ld_idx + AW'(3)];

    always_comb begin
        case (i_size)
            MEM_BYTE: o_load_data = i_unsigned ? {24'h0, ld_b0} : {{24{ld_b0[7]}}, ld_b0};
            MEM_HALF: o_load_data = i_unsigned ? {16'h0, ld_b1, ld_b0} :
                                                 {{16{ld_b1[7]}}, ld_b1, ld_b0};
            default:  o_load_data = {ld_b3, ld_b2, ld_b1, ld_b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            if (i_prog_en) begin                        // program load while core is held
                mem[prog_idx] <= i_prog_data;
            end
        end else if (in_range) begin
            for (int k = 0; k < 4; k++) begin
                if (i_byte_en[k]) begin
                    mem[{st_word, k[1:0]}] <= i_store_data[8*k +: 8];
                end
            end
        end
    end

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN = 32;                   // data and address width

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    //////////////////////////////
    // control encodings

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B                              // lui
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_t;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_t;

    //////////////////////////////
    // rv32i base opcodes

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam int unsigned DEFAULT_MEM_BYTES    = 32768;
    localparam word_t       DEFAULT_UART_TX_ADDR = 32'h0002_0020;
    localparam word_t       RESET_PC             = 32'h0000_0000;

endpackage

/* hdl/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  logic             i_we,
    input  logic             i_load,
    input  rv_pkg::word_t    i_alu_result,
    input  rv_pkg::word_t    i_load_data,
    output rv_pkg::word_t    o_rs1_data,
    output rv_pkg::word_t    o_rs2_data
);
    import rv_pkg::*;

    word_t regs [1:31];                                 // x0 has no storage
    word_t wb_data;

    assign wb_data = i_load ? i_load_data : i_alu_result;

    // x0 always reads zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk) begin
        if (i_we && (i_rd != '0)) begin                 // writes to x0 are dropped
            regs[i_rd] <= wb_data;
        end
    end

endmodule

/* include/tb_rv_iss.svh */
`ifndef TB_RV_ISS_SVH
`define TB_RV_ISS_SVH

logic [7:0]  model_mem [DEFAULT_MEM_BYTES];             // model copy of the unified memory
logic [31:0] xreg [32];

function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic [31:0]        r;
    sa = a;
    case (f3)
        3'd0:    r = alt ? a - b : a + b;
        3'd1:    r = a << b[4:0];
        3'd2:    r = {31'd0, sa < $signed(b)};           // slt writes back 0 or 1
        3'd3:    r = {31'd0, a < b};
        3'd4:    r = a ^ b;
        3'd5: begin
            if (alt) begin
                r = sa >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'd6:    r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] ea);
    logic [31:0] w;
    w = {model_mem[ea + 3], model_mem[ea + 2], model_mem[ea + 1], model_mem[ea]};
    case (f3)
        3'd0:    return {{24{w[7]}}, w[7:0]};
        3'd1:    return {{16{w[15]}}, w[15:0]};
        3'd4:    return {24'd0, w[7:0]};
        3'd5:    return {16'd0, w[15:0]};
        default: return w;
    endcase
endfunction

// runs program p to its final self-loop and queues the uart bytes
task automatic run_model(input int p);
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] val;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic        wr;
    int          steps;
    for (int r = 0; r < 32; r++) begin
        xreg[r] = '0;
    end
    for (int i = 0; i < prog_len[p]; i++) begin
        for (int k = 0; k < 4; k++) begin
            model_mem[4 * i + k] = progs[p][i][8*k +: 8];
        end
    end
    exp_bytes.delete();
    pc    = RESET_PC;
    steps = 0;
    forever begin
        inst    = {model_mem[pc + 3], model_mem[pc + 2], model_mem[pc + 1], model_mem[pc]};
        f3      = inst[14:12];
        a       = xreg[inst[19:15]];
        b       = xreg[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        next_pc = pc + 32'd4;
        wr      = 1'b1;
        val     = '0;
        case (inst[6:0])
            OPC_LUI:    val = {inst[31:12], 12'd0};
            OPC_AUIPC:  val = pc + {inst[31:12], 12'd0};
            OPC_JAL: begin
                val     = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            OPC_JALR: begin
                val     = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    next_pc = pc + imm_b;
                end
            end
            OPC_LOAD:   val = load_value(f3, a + imm_i);
            OPC_STORE: begin
                wr = 1'b0;
                ea = a + imm_s;
                if (f3 == 3'd0 && ea == DEFAULT_UART_TX_ADDR) begin
                    exp_bytes.push_back(b[7:0]);
                end
                if (ea < DEFAULT_MEM_BYTES) begin
                    for (int k = 0; k < (1 << f3); k++) begin
                        model_mem[ea + k] = b[8*k +: 8];
                    end
                end
            end
            OPC_OP_IMM: val = alu_result(f3, (f3 == 3'd5) && inst[30], a, imm_i);
            OPC_OP:     val = alu_result(f3, inst[30], a, b);
            default:    wr = 1'b0;                  // anything else is a no-op
        endcase
        if (wr && inst[11:7] != 5'd0) begin
            xreg[inst[11:7]] = val;
        end
        steps++;
        if (next_pc == pc) begin
            break;
        end
        if (steps > 4 * MAX_WORDS) begin
            errors++;
            $display("model never reached the final loop of program %0d", p);
            break;
        end
        pc = next_pc;
    end
endtask

`endif

/* test/tb_riscv_core.sv */
`timescale 1ns/1ns

module tb_riscv_core;
    import rv_pkg::*;

    localparam int NUM_PROGS = 4;
    localparam int MAX_WORDS = 1024;

    logic        clk;
    logic        reset;
    logic        i_prog_en;
    word_t       i_prog_addr;
    logic [7:0]  i_prog_data;
    logic        o_uart_en;
    logic [7:0]  o_uart_data;

    logic [31:0] progs [NUM_PROGS][MAX_WORDS];
    int          prog_len [NUM_PROGS];
    logic [7:0]  exp_bytes [$];                         // bytes the model predicts
    int          errors;
    int          strobes;
    int          checked;
    longint      limit_ns = 0;

    `include "tb_rv_iss.svh"

    riscv_core dut (
        .clk(clk), .reset(reset), .i_prog_en(i_prog_en), .i_prog_addr(i_prog_addr),
        .i_prog_data(i_prog_data), .o_uart_en(o_uart_en), .o_uart_data(o_uart_data)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %0h got %0h", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    //////////////////////////////
    // instruction encoders

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [4:0] work_reg();
        return 5'($urandom_range(1, 28));               // x29..x31 are reserved
    endfunction

    function automatic logic [4:0] dest_reg();
        return ($urandom_range(0, 7) == 0) ? 5'd0 : work_reg();
    endfunction

    task automatic emit(input int p, input logic [31:0] w);
        progs[p][prog_len[p]] = w;
        prog_len[p]++;
    endtask

    //////////////////////////////
    // random program build

    task automatic build_program(input int p);
        logic [2:0]  conds [6];
        logic [2:0]  lds [5];
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [11:0] off;
        int          size;
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        lds   = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        prog_len[p] = 0;
        emit(p, u_type(20'h00004, 5'd30, OPC_LUI));     // data region base
        emit(p, u_type(20'h00020, 5'd31, OPC_LUI));     // uart tx address
        emit(p, i_type(12'h020, 5'd31, 3'd0, 5'd31, OPC_OP_IMM));
        for (int r = 1; r <= 28; r++) begin
            emit(p, u_type(20'($urandom), 5'(r), OPC_LUI));
            emit(p, i_type(12'($urandom), 5'(r), 3'd0, 5'(r), OPC_OP_IMM));
        end
        for (int n = 0; n < 40; n++) begin
            f3 = 3'($urandom);
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            if ($urandom_range(0, 1) == 1) begin
                emit(p, r_type(f7, work_reg(), work_reg(), f3, dest_reg()));
            end else begin
                off = (f3 == 3'd1 || f3 == 3'd5) ? {f7, 5'($urandom)} : 12'($urandom);
                emit(p, i_type(off, work_reg(), f3, dest_reg(), OPC_OP_IMM));
            end
        end
        for (int n = 0; n < 12; n++) begin
            rs1 = work_reg();
            rd  = work_reg();
            emit(p, b_type(13'd8, ($urandom_range(0, 3) == 0) ? rs1 : work_reg(), rs1,
                           conds[$urandom_range(0, 5)]));
            emit(p, i_type(12'($urandom), rd, 3'd0, rd, OPC_OP_IMM));   // skipped if taken
        end
        for (int n = 0; n < 4; n++) begin
            rd = work_reg();
            emit(p, j_type(21'd8, dest_reg()));
            emit(p, i_type(12'd1, rd, 3'd0, rd, OPC_OP_IMM));
            emit(p, u_type(20'd0, 5'd28, OPC_AUIPC));
            emit(p, i_type(12'd12, 5'd28, 3'd0, dest_reg(), OPC_JALR));
            emit(p, i_type(12'd1, rd, 3'd0, rd, OPC_OP_IMM));
        end
        for (int n = 0; n < 3; n++) begin
            emit(p, u_type(20'($urandom), dest_reg(), OPC_LUI));
            emit(p, u_type(20'($urandom), dest_reg(), OPC_AUIPC));
        end
        for (int k = 0; k < 16; k++) begin
            emit(p, s_type(12'(4 * k), work_reg(), 5'd30, 3'd2));      // fill the region
        end
        for (int n = 0; n < 12; n++) begin
            size = $urandom_range(0, 2);
            off  = 12'(($urandom_range(0, 63) >> size) << size);
            emit(p, s_type(off, work_reg(), 5'd30, 3'(size)));
        end
        for (int n = 0; n < 12; n++) begin
            f3  = lds[$urandom_range(0, 4)];
            off = 12'(($urandom_range(0, 63) >> f3[1:0]) << f3[1:0]);
            emit(p, i_type(off, 5'd30, f3, dest_reg(), OPC_LOAD));
        end
        for (int r = 0; r < 32; r++) begin
            emit(p, i_type(12'd0, 5'(r), 3'd0, 5'd29, OPC_OP_IMM));
            for (int k = 0; k < 4; k++) begin
                emit(p, s_type(12'd0, 5'd29, 5'd31, 3'd0));
                if (k < 3) begin
                    emit(p, i_type(12'd8, 5'd29, 3'd5, 5'd29, OPC_OP_IMM));   // srli 8
                end
            end
        end
        emit(p, j_type(21'd0, 5'd0));                   // park here
    endtask

    task automatic load_program(input int p);
        logic [31:0] uart_sb;
        uart_sb = s_type(12'd0, 5'd0, 5'd31, 3'd0);     // uart sb that first sits at the reset pc
        reset   = 1'b1;
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            i_prog_en   = 1'b1;
            i_prog_addr = 32'(k);
            i_prog_data = uart_sb[8*k +: 8];
        end
        for (int i = 0; i < prog_len[p]; i++) begin
            for (int k = 0; k < 4; k++) begin
                next_cycle();
                i_prog_en   = 1'b1;
                i_prog_addr = 32'(4 * i + k);
                i_prog_data = progs[p][i][8*k +: 8];
            end
        end
        next_cycle();
        i_prog_en = 1'b0;
        repeat (3) next_cycle();
    endtask

    // uart monitor sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            if (o_uart_en !== 1'b0) begin
                errors++;
                $display("uart strobe was not low while reset was held");
            end
        end else if ($isunknown(o_uart_en)) begin
            errors++;
            $display("uart strobe is unknown");
        end else if (o_uart_en) begin
            strobes++;
            if (exp_bytes.size() == 0) begin
                errors++;
                $display("uart strobe came with no byte left to expect");
            end else begin
                check_value("o_uart_data", exp_bytes.pop_front(), o_uart_data);
                checked++;
            end
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog ran out after %0d ns while waiting for uart bytes", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        longint total;
        int     expected;
        void'($urandom(13603));
        clk         = 1'b0;
        reset       = 1'b1;
        i_prog_en   = 1'b0;
        i_prog_addr = '0;
        i_prog_data = '0;
        errors      = 0;
        strobes     = 0;
        checked     = 0;
        total       = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            build_program(p);
            total += 5 * prog_len[p] + 5;               // run plus load and reset cycles
        end
        limit_ns = total * 40 * 4;
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_model(p);
            load_program(p);
            expected = exp_bytes.size();
            strobes  = 0;
            reset    = 1'b0;
            while (exp_bytes.size() != 0) begin
                next_cycle();
            end
            repeat (50) next_cycle();                   // nothing more once parked
            check_value("o_uart_en count", 32'(expected), 32'(strobes));
        end
        $display("errors: %0d  uart bytes checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
